// ==== sim.f ====
common/conf_pkg.sv
common/fu_pkg.sv
conf/conf_ctrl.sv
conf/conf_reg.sv
conf/conf_mem.sv
logic/fu_slot.sv
logic/conf_engine_top.sv
testbench/tb_conf_engine.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_conf_engine \
   -f sim.f -o tb_conf_engine > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_conf_engine > sim.log 2>&1
grep -q "^Simulation finished: PASS$" sim.log && { echo "run passed"; exit 0; } \
   || { echo "run failed, see sim.log"; exit 1; }

// ==== testbench/tb_conf_engine.sv ====
module tb_conf_engine
   import conf_pkg::*;
   import fu_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int N_SLOTS    = 2;
   localparam int DW         = 16;
   localparam int MEM_DEPTH  = 4;
   localparam int MAX_CYCLES = 4000;

   logic          clk = 1'b0;
   logic          arst_n;
   apb_req_t      apb_req;
   apb_rsp_t      apb_rsp;
   logic          in_valid;
   logic [DW-1:0] in_a;
   logic [DW-1:0] in_b;
   logic          out_valid;
   logic [DW-1:0] out_data;

   // expected results, oldest first
   logic [DW-1:0] exp_q [$];
   logic [15:0]   shadow [N_SLOTS];
   logic [31:0]   lcg_state = 32'd11689;
   int            err_count = 0;
   int            check_count = 0;
   int            test_count = 0;
   int            test_err_base = 0;
   int            valid_run = 0;
   int            max_run = 0;
   int            cycle_count = 0;

   conf_engine_top uut (
      .clk, .arst_n, .apb_req, .apb_rsp,
      .in_valid, .in_a, .in_b, .out_valid, .out_data
   );

   always #10 clk = ~clk;

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= MAX_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   task automatic report_fail(input string msg);
      err_count++;
      $display("Fail at %0t: %s", $time, msg);
   endtask

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
      check_count++;
      assert (got === exp)
         else report_fail($sformatf("%s is %0h, expected %0h", what, got, exp));
   endtask

   // stream latency is fixed by the chain length
   latency_check: assert property (@(posedge clk) disable iff (!arst_n)
      out_valid == $past(in_valid, N_SLOTS))
      else report_fail("out_valid does not follow in_valid by N_SLOTS cycles");

   error_with_ready: assert property (@(posedge clk) disable iff (!arst_n)
      apb_rsp.pslverr |-> apb_rsp.pready)
      else report_fail("pslverr raised without pready");

   // 15-bit lcg output
   function automatic logic [14:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state[30:16];
   endfunction

   function automatic logic [15:0] rand16();
      logic [14:0] hi;
      logic [14:0] lo;
      hi = lcg_next();
      lo = lcg_next();
      return {hi[7:0], lo[7:0]};
   endfunction

   // one slot, decoded from the raw word
   function automatic logic [DW-1:0] slot_model(input logic [15:0] conf,
                                                input logic [DW-1:0] a, input logic [DW-1:0] b);
      logic [DW-1:0] bb;
      longint        prod;
      int            sh;
      bb = conf[11] ? ~b : b;
      sh = int'(conf[14:11]);
      if (conf[15]) begin
         if (conf[10]) begin
            prod = longint'($signed(a)) * longint'($signed(b));
            prod = prod >>> sh;
         end else begin
            prod = longint'(a) * longint'(b);
            prod = prod >> sh;
         end
         return prod[DW-1:0];
      end
      case (conf[14:12])
         3'd0:    return a + bb;
         3'd1:    return a - bb;
         3'd2:    return a & bb;
         3'd3:    return a | bb;
         3'd4:    return a ^ bb;
         3'd6:    return (a < bb) ? a : bb;
         3'd7:    return (a > bb) ? a : bb;
         default: return a;
      endcase
   endfunction

   function automatic logic [DW-1:0] chain_model(input logic [DW-1:0] a, input logic [DW-1:0] b);
      logic [DW-1:0] acc;
      acc = a;
      for (int k = 0; k < N_SLOTS; k++)
         acc = slot_model(shadow[k], acc, b);
      return acc;
   endfunction

   // called 2 ns after a rising edge, returns at the same point
   task automatic apb_xfer(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output int waits, output logic err);
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = write;
      apb_req.paddr   = addr;
      apb_req.pwdata  = wdata;
      @(posedge clk);
      #2;
      apb_req.penable = 1'b1;
      waits = 0;
      @(negedge clk);
      while (!apb_rsp.pready) begin
         waits++;
         @(negedge clk);
      end
      rdata = apb_rsp.prdata;
      err   = apb_rsp.pslverr;
      @(posedge clk);
      #2;
      apb_req.psel    = 1'b0;
      apb_req.penable = 1'b0;
   endtask

   task automatic slot_write(input int idx, input logic [31:0] data);
      logic [31:0] rdata;
      int          waits;
      logic        err;
      apb_xfer(1'b1, 8'(idx), data, rdata, waits, err);
      check_value(waits, 0, "slot write wait cycles");
      check_value(err, 0, "slot write pslverr");
      shadow[idx] = data[15:0];
   endtask

   task automatic slot_read_check(input int idx, input logic [15:0] exp);
      logic [31:0] rdata;
      int          waits;
      logic        err;
      apb_xfer(1'b0, 8'(idx), 32'h0, rdata, waits, err);
      check_value(rdata, {16'h0, exp}, $sformatf("slot %0d readback", idx));
      check_value(waits, 0, "slot read wait cycles");
      check_value(err, 0, "slot read pslverr");
   endtask

   task automatic send_item(input logic [DW-1:0] a, input logic [DW-1:0] b);
      in_valid = 1'b1;
      in_a     = a;
      in_b     = b;
      exp_q.push_back(chain_model(a, b));
      @(posedge clk);
      #2;
   endtask

   task automatic drain();
      in_valid = 1'b0;
      while (exp_q.size() != 0) begin
         @(posedge clk);
         #2;
      end
   endtask

   task automatic finish_test(input string name);
      test_count++;
      $display("test %0d %s: %0d errors", test_count, name, err_count - test_err_base);
      test_err_base = err_count;
   endtask

   always @(negedge clk) begin : out_monitor
      logic [DW-1:0] exp_data;
      if (arst_n && out_valid) begin
         // longest run of results on consecutive cycles
         valid_run++;
         if (valid_run > max_run)
            max_run = valid_run;
         assert (exp_q.size() > 0)
            else report_fail("out_valid with no item in flight");
         if (exp_q.size() > 0) begin
            exp_data = exp_q.pop_front();
            check_value(out_data, exp_data, "out_data");
         end
      end else begin
         valid_run = 0;
      end
   end

   initial begin
      logic [31:0] rdata;
      int          waits;
      logic        err;
      logic [15:0] saved [N_SLOTS];
      logic [15:0] word;
      logic [7:0]  bad_addr [5];
      int          shifts [4];
      int          sel;
      arst_n   = 1'b0;
      apb_req  = '0;
      in_valid = 1'b0;
      in_a     = '0;
      in_b     = '0;
      shifts   = '{0, 3, 8, 15};
      bad_addr = '{8'(N_SLOTS), 8'h1f, 8'h40, MEM_SAVE_BASE + 8'(MEM_DEPTH), MEM_LOAD_BASE + 8'hf};
      for (int k = 0; k < N_SLOTS; k++)
         shadow[k] = '0;
      repeat (5) @(posedge clk);
      #2;
      arst_n = 1'b1;

      @(negedge clk);
      check_value(apb_rsp.pready, 0, "pready after reset");
      check_value(apb_rsp.pslverr, 0, "pslverr after reset");
      check_value(out_valid, 0, "out_valid after reset");
      @(posedge clk);
      #2;
      for (int k = 0; k < N_SLOTS; k++)
         slot_read_check(k, 16'h0);
      word = rand16();
      sel  = int'(lcg_next()) % N_SLOTS;
      slot_write(sel, {rand16(), word});
      slot_read_check(sel, word);
      finish_test("reset and slot access");

      for (int op = 0; op < 8; op++) begin
         for (int inv = 0; inv < 2; inv++) begin
            for (int k = 0; k < N_SLOTS; k++)
               slot_write(k, {16'h0, 1'b0, 3'(op), 1'(inv), 11'h0});
            repeat (6) send_item(rand16(), rand16());
            drain();
         end
      end
      finish_test("alu ops");

      for (int sm = 0; sm < 2; sm++) begin
         for (int i = 0; i < 4; i++) begin
            slot_write(0, {16'h0, 1'b1, 4'(shifts[i]), 1'(sm), 10'h0});
            // later slots pass the product through
            for (int k = 1; k < N_SLOTS; k++)
               slot_write(k, {16'h0, 1'b0, 3'd5, 12'h0});
            send_item(16'hfff3, 16'h8005);
            send_item(16'h8000, 16'h7fff);
            repeat (4) send_item(rand16(), rand16());
            drain();
         end
      end
      finish_test("multiplier");

      for (int k = 0; k < N_SLOTS; k++)
         slot_write(k, {16'h0, rand16()});
      for (int k = 0; k < N_SLOTS; k++)
         saved[k] = shadow[k];
      apb_xfer(1'b1, MEM_SAVE_BASE + 8'd1, 32'h0, rdata, waits, err);
      check_value(waits, 0, "save wait cycles");
      check_value(err, 0, "save pslverr");
      for (int k = 0; k < N_SLOTS; k++)
         slot_write(k, {16'h0, ~saved[k]});
      apb_xfer(1'b1, MEM_LOAD_BASE + 8'd1, 32'h0, rdata, waits, err);
      check_value(waits, 1, "load wait cycles");
      check_value(err, 0, "load pslverr");
      for (int k = 0; k < N_SLOTS; k++) begin
         shadow[k] = saved[k];
         slot_read_check(k, saved[k]);
      end
      repeat (4) send_item(rand16(), rand16());
      drain();
      finish_test("snapshot save and load");

      for (int i = 0; i < 5; i++) begin
         apb_xfer(1'b1, bad_addr[i], {16'h0, rand16()}, rdata, waits, err);
         check_value(err, 1, $sformatf("pslverr at address %0h", bad_addr[i]));
         check_value(waits, 0, "error wait cycles");
         check_value(rdata, 0, "prdata on error");
      end
      apb_xfer(1'b0, 8'hff, 32'h0, rdata, waits, err);
      check_value(err, 1, "pslverr on unmapped read");
      check_value(rdata, 0, "prdata on unmapped read");
      // snapshot regions read as zero without an error
      apb_xfer(1'b0, MEM_SAVE_BASE + 8'hf, 32'h0, rdata, waits, err);
      check_value(err, 0, "pslverr on snapshot region read");
      check_value(rdata, 0, "prdata on snapshot region read");
      for (int k = 0; k < N_SLOTS; k++)
         slot_read_check(k, shadow[k]);
      finish_test("error responses");

      for (int k = 0; k < N_SLOTS; k++)
         slot_write(k, {16'h0, rand16()});
      max_run = 0;
      repeat (20) send_item(rand16(), rand16());
      drain();
      check_value(max_run, 20, "consecutive results in back-to-back stream");
      finish_test("back-to-back stream");

      $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
      if (err_count == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// ==== logic/conf_engine_top.sv ====
module conf_engine_top
   import conf_pkg::*;
   import fu_pkg::*;
#(
   parameter int N_SLOTS        = 2,
   parameter int DATA_W         = 16,
   parameter int CONF_MEM_DEPTH = 4,
   localparam int SEL_W = (N_SLOTS > 1) ? $clog2(N_SLOTS) : 1,
   localparam int IDX_W = (CONF_MEM_DEPTH > 1) ? $clog2(CONF_MEM_DEPTH) : 1
) (
   input  logic              clk,
   input  logic              arst_n,

   input  apb_req_t          apb_req,
   output apb_rsp_t          apb_rsp,

   input  logic              in_valid,
   input  logic [DATA_W-1:0] in_a,
   input  logic [DATA_W-1:0] in_b,

   output logic              out_valid,
   output logic [DATA_W-1:0] out_data
);

   slot_conf_u [N_SLOTS-1:0] conf_bank;
   slot_conf_u [N_SLOTS-1:0] snap_data;
   slot_conf_u               reg_wdata;
   logic [SEL_W-1:0]         reg_sel;
   logic [IDX_W-1:0]         mem_idx;
   logic                     reg_we;
   logic                     mem_save;
   logic                     mem_load;
   logic                     snap_ld;

   conf_ctrl #(.N_SLOTS(N_SLOTS), .CONF_MEM_DEPTH(CONF_MEM_DEPTH)) u_conf_ctrl (
      .clk, .arst_n, .apb_req, .apb_rsp, .conf_bank,
      .reg_we, .reg_sel, .reg_wdata, .mem_save, .mem_load, .mem_idx
   );

   conf_reg #(.N_SLOTS(N_SLOTS)) u_conf_reg (
      .clk, .arst_n, .reg_we, .reg_sel, .reg_wdata, .snap_ld, .snap_data, .conf_bank
   );

   conf_mem #(.N_SLOTS(N_SLOTS), .CONF_MEM_DEPTH(CONF_MEM_DEPTH)) u_conf_mem (
      .clk, .arst_n, .mem_save, .mem_load, .mem_idx, .conf_bank, .snap_data, .snap_ld
   );

   // stage k sees its item k cycles after entry
   logic              valid_chain [N_SLOTS+1];
   logic [DATA_W-1:0] a_chain     [N_SLOTS+1];
   logic [DATA_W-1:0] b_stage     [N_SLOTS];

   assign valid_chain[0] = in_valid;
   assign a_chain[0]     = in_a;

   for (genvar k = 0; k < N_SLOTS; k++) begin : g_slot
      if (k == 0) begin : g_b_in
         assign b_stage[k] = in_b;
      end else begin : g_b_dly
         // operand b follows its item down the chain
         always_ff @(posedge clk) begin
            b_stage[k] <= b_stage[k-1];
         end
      end

      fu_slot #(.DATA_W(DATA_W)) u_fu_slot (
         .clk, .arst_n,
         .conf      (conf_bank[k]),
         .in_valid  (valid_chain[k]),
         .in_a      (a_chain[k]),
         .in_b      (b_stage[k]),
         .out_valid (valid_chain[k+1]),
         .out_data  (a_chain[k+1])
      );
   end

   assign out_valid = valid_chain[N_SLOTS];
   assign out_data  = a_chain[N_SLOTS];

endmodule

// ==== logic/fu_slot.sv ====
module fu_slot
   import fu_pkg::*;
#(
   parameter int DATA_W = 16
) (
   input  logic              clk,
   input  logic              arst_n,

   input  slot_conf_u        conf,

   input  logic              in_valid,
   input  logic [DATA_W-1:0] in_a,
   input  logic [DATA_W-1:0] in_b,

   output logic              out_valid,
   output logic [DATA_W-1:0] out_data
);

   logic [DATA_W-1:0] b_eff;
   logic [DATA_W-1:0] alu_res;
   logic [DATA_W-1:0] mul_res;
   logic [DATA_W-1:0] result;

   logic signed [2*DATA_W-1:0] prod_s;
   logic signed [2*DATA_W-1:0] shr_s;
   logic [2*DATA_W-1:0]        prod_u;
   logic [2*DATA_W-1:0]        shr_u;

   // alu view
   assign b_eff = conf.alu.invert_b ? ~in_b : in_b;

   always_comb begin
      case (conf.alu.op)
         ALU_ADD:    alu_res = in_a + b_eff;
         ALU_SUB:    alu_res = in_a - b_eff;
         ALU_AND:    alu_res = in_a & b_eff;
         ALU_OR:     alu_res = in_a | b_eff;
         ALU_XOR:    alu_res = in_a ^ b_eff;
         ALU_PASS_A: alu_res = in_a;
         // unsigned compare
         ALU_MIN:    alu_res = (in_a < b_eff) ? in_a : b_eff;
         ALU_MAX:    alu_res = (in_a > b_eff) ? in_a : b_eff;
         default:    alu_res = in_a;
      endcase
   end

   // multiplier view, full product then shift
   assign prod_s = $signed(in_a) * $signed(in_b);
   assign prod_u = in_a * in_b;

   // kept apart so the signed shift stays arithmetic
   assign shr_s = prod_s >>> conf.mul.shift;
   assign shr_u = prod_u >> conf.mul.shift;

   assign mul_res = conf.mul.signed_mode ? shr_s[DATA_W-1:0] : shr_u[DATA_W-1:0];

   assign result = (conf.alu.kind == FU_MUL) ? mul_res : alu_res;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      out_data <= result;
   end

endmodule

// ==== conf/conf_mem.sv ====
module conf_mem
   import conf_pkg::*;
#(
   parameter int N_SLOTS        = 2,
   parameter int CONF_MEM_DEPTH = 4,
   localparam int IDX_W = (CONF_MEM_DEPTH > 1) ? $clog2(CONF_MEM_DEPTH) : 1
) (
   input  logic                     clk,
   input  logic                     arst_n,

   input  logic                     mem_save,
   input  logic                     mem_load,
   input  logic [IDX_W-1:0]         mem_idx,

   input  conf_word_t [N_SLOTS-1:0] conf_bank,

   output conf_word_t [N_SLOTS-1:0] snap_data,
   output logic                     snap_ld
);

   // one entry holds a full bank
   conf_word_t [N_SLOTS-1:0] mem [CONF_MEM_DEPTH];

   always_ff @(posedge clk) begin
      if (mem_save)
         mem[mem_idx] <= conf_bank;
   end

   // synchronous read, data lines up with snap_ld
   always_ff @(posedge clk) begin
      if (mem_load)
         snap_data <= mem[mem_idx];
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         snap_ld <= 1'b0;
      end else begin
         snap_ld <= mem_load;
      end
   end

endmodule

// ==== conf/conf_reg.sv ====
module conf_reg
   import fu_pkg::*;
#(
   parameter int N_SLOTS = 2,
   localparam int SEL_W = (N_SLOTS > 1) ? $clog2(N_SLOTS) : 1
) (
   input  logic                     clk,
   input  logic                     arst_n,

   // single slot write from the apb side
   input  logic                     reg_we,
   input  logic [SEL_W-1:0]         reg_sel,
   input  slot_conf_u               reg_wdata,

   // whole bank from the snapshot memory
   input  logic                     snap_ld,
   input  slot_conf_u [N_SLOTS-1:0] snap_data,

   output slot_conf_u [N_SLOTS-1:0] conf_bank
);

   slot_conf_u [N_SLOTS-1:0] bank_q;
   slot_conf_u [N_SLOTS-1:0] bank_d;

   // snapshot load wins over a slot write in the same cycle
   always_comb begin
      bank_d = bank_q;
      if (snap_ld) begin
         bank_d = snap_data;
      end else if (reg_we) begin
         for (int i = 0; i < N_SLOTS; i++) begin
            if (reg_sel == SEL_W'(i))
               bank_d[i] = reg_wdata;
         end
      end
   end

   // cleared bank means every slot adds without inversion
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         bank_q <= '0;
      end else begin
         bank_q <= bank_d;
      end
   end

   assign conf_bank = bank_q;

endmodule

// ==== conf/conf_ctrl.sv ====
module conf_ctrl
   import conf_pkg::*;
   import fu_pkg::*;
#(
   parameter int N_SLOTS         = 2,
   parameter int CONF_MEM_DEPTH  = 4,
   localparam int SEL_W = (N_SLOTS > 1) ? $clog2(N_SLOTS) : 1,
   localparam int IDX_W = (CONF_MEM_DEPTH > 1) ? $clog2(CONF_MEM_DEPTH) : 1
) (
   input  logic                     clk,
   input  logic                     arst_n,

   input  apb_req_t                 apb_req,
   output apb_rsp_t                 apb_rsp,

   input  slot_conf_u [N_SLOTS-1:0] conf_bank,

   output logic                     reg_we,
   output logic [SEL_W-1:0]         reg_sel,
   output slot_conf_u               reg_wdata,

   output logic                     mem_save,
   output logic                     mem_load,
   output logic [IDX_W-1:0]         mem_idx
);

   typedef enum logic {
      LD_IDLE,
      LD_WAIT
   } ld_state_e;

   ld_state_e ld_state;

   region_e region;
   logic    access;
   logic    idx_ok;
   logic    load_req;
   logic    load_first;
   logic    err;

   assign access = apb_req.psel & apb_req.penable;

   // address decode
   always_comb begin
      if (int'(apb_req.paddr) < N_SLOTS)
         region = REGION_SLOT;
      else if (apb_req.paddr[ADDR_W-1:SNAP_IDX_W] == MEM_SAVE_BASE[ADDR_W-1:SNAP_IDX_W])
         region = REGION_SAVE;
      else if (apb_req.paddr[ADDR_W-1:SNAP_IDX_W] == MEM_LOAD_BASE[ADDR_W-1:SNAP_IDX_W])
         region = REGION_LOAD;
      else
         region = REGION_NONE;
   end

   assign idx_ok = int'(apb_req.paddr[SNAP_IDX_W-1:0]) < CONF_MEM_DEPTH;

   // snapshot reads are harmless, only writes check the index
   assign err = (region == REGION_NONE) |
                (apb_req.pwrite & (region inside {REGION_SAVE, REGION_LOAD}) & ~idx_ok);

   assign load_req   = apb_req.pwrite & (region == REGION_LOAD) & idx_ok;
   assign load_first = access & load_req & (ld_state == LD_IDLE);

   // write strobes
   assign reg_we    = access & apb_req.pwrite & (region == REGION_SLOT);
   assign reg_sel   = apb_req.paddr[SEL_W-1:0];
   assign reg_wdata = apb_req.pwdata[CONF_W-1:0];

   assign mem_save  = access & apb_req.pwrite & (region == REGION_SAVE) & idx_ok;
   assign mem_load  = load_first;
   assign mem_idx   = apb_req.paddr[IDX_W-1:0];

   // one wait cycle while the snapshot memory reads
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ld_state <= LD_IDLE;
      end else begin
         ld_state <= load_first ? LD_WAIT : LD_IDLE;
      end
   end

   assign apb_rsp.pready  = access & ~load_first;
   assign apb_rsp.pslverr = access & err;

   // readback, slot words zero-extended
   always_comb begin
      apb_rsp.prdata = '0;
      if (!apb_req.pwrite && region == REGION_SLOT)
         apb_rsp.prdata[CONF_W-1:0] = conf_bank[reg_sel];
   end

endmodule

// ==== common/fu_pkg.sv ====
package fu_pkg;

   typedef enum logic {
      FU_ALU = 1'b0,
      FU_MUL = 1'b1
   } fu_kind_e;

   // zero encoding is add, so a cleared bank is a chain of adders
   typedef enum logic [2:0] {
      ALU_ADD    = 3'd0,
      ALU_SUB    = 3'd1,
      ALU_AND    = 3'd2,
      ALU_OR     = 3'd3,
      ALU_XOR    = 3'd4,
      ALU_PASS_A = 3'd5,
      ALU_MIN    = 3'd6,
      ALU_MAX    = 3'd7
   } alu_op_e;

   typedef struct packed {
      fu_kind_e    kind;
      alu_op_e     op;
      logic        invert_b;
      logic [10:0] pad;
   } alu_conf_t;

   typedef struct packed {
      fu_kind_e    kind;
      logic [3:0]  shift;
      logic        signed_mode;
      logic [9:0]  pad;
   } mul_conf_t;

   // kind sits at the top bit of both views
   typedef union packed {
      alu_conf_t alu;
      mul_conf_t mul;
   } slot_conf_u;

endpackage

// ==== common/conf_pkg.sv ====
package conf_pkg;

   // apb side of the configuration subsystem
   localparam int ADDR_W = 8;
   localparam int CONF_W = 16;

   // snapshot regions are 16 words each, index in the low bits
   localparam int SNAP_IDX_W = 4;

   localparam logic [ADDR_W-1:0] MEM_SAVE_BASE = 8'h20;
   localparam logic [ADDR_W-1:0] MEM_LOAD_BASE = 8'h30;

   // address regions seen by the decoder
   typedef enum logic [1:0] {
      REGION_SLOT,
      REGION_SAVE,
      REGION_LOAD,
      REGION_NONE
   } region_e;

   // driven by the host
   typedef struct packed {
      logic              psel;
      logic              penable;
      logic              pwrite;
      logic [ADDR_W-1:0] paddr;
      logic [31:0]       pwdata;
   } apb_req_t;

   // driven by the slave
   typedef struct packed {
      logic [31:0] prdata;
      logic        pready;
      logic        pslverr;
   } apb_rsp_t;

   // raw view of one slot word, as stored in a snapshot
   typedef logic [CONF_W-1:0] conf_word_t;

endpackage
